//--- Bender.yml
package:
  name: spm_cpu

sources:
  - rtl/mem_pkg.sv
  - rtl/isa_pkg.sv
  - rtl/if_stage.sv
  - rtl/decoder.sv
  - rtl/gpr.sv
  - rtl/alu.sv
  - rtl/mem_ctrl.sv
  - rtl/spm.sv
  - rtl/cpu_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/tb_cpu_top.sv

//--- filelist.f
rtl/mem_pkg.sv
rtl/isa_pkg.sv
rtl/if_stage.sv
rtl/decoder.sv
rtl/gpr.sv
rtl/alu.sv
rtl/mem_ctrl.sv
rtl/spm.sv
rtl/cpu_top.sv
tests/tb_clock.sv
tests/tb_cpu_top.sv

//--- rtl/alu.sv
module alu (
    input  logic [isa_pkg::ALU_OP_W-1:0] alu_op,
    input  logic [mem_pkg::DATA_W-1:0]   alu_in_0,
    input  logic [mem_pkg::DATA_W-1:0]   alu_in_1,
    output logic [mem_pkg::DATA_W-1:0]   alu_out
);

    localparam int SHAMT_W = $clog2(mem_pkg::DATA_W);

    logic [SHAMT_W-1:0] shamt;

    assign shamt = alu_in_1[SHAMT_W-1:0];

    always_comb begin
        case (alu_op)
            isa_pkg::alu_add: alu_out = alu_in_0 + alu_in_1;
            isa_pkg::alu_sub: alu_out = alu_in_0 - alu_in_1;
            isa_pkg::alu_and: alu_out = alu_in_0 & alu_in_1;
            isa_pkg::alu_or: alu_out = alu_in_0 | alu_in_1;
            isa_pkg::alu_xor: alu_out = alu_in_0 ^ alu_in_1;
            // both shifts are logical so zeros come in
            isa_pkg::alu_shl: alu_out = alu_in_0 << shamt;
            isa_pkg::alu_shr: alu_out = alu_in_0 >> shamt;
            default: alu_out = '0;
        endcase
    end

endmodule

//--- rtl/cpu_top.sv
module cpu_top #(
    parameter int spm_depth = mem_pkg::SPM_DEPTH_DEFAULT
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            cpu_en,
    input  logic                            test_spm_en,
    input  logic                            test_spm_we,
    input  logic [mem_pkg::WORD_ADDR_W-1:0] test_spm_addr,
    input  logic [mem_pkg::DATA_W-1:0]      test_spm_wr_data,
    output logic [mem_pkg::DATA_W-1:0]      test_spm_rd_data,
    output logic                            halted
);

    localparam int OFFSET_W = mem_pkg::BYTE_ADDR_W - mem_pkg::WORD_ADDR_W;

    logic [mem_pkg::DATA_W-1:0] pc;
    logic fetch_en;
    logic [mem_pkg::DATA_W-1:0] insn;
    logic br_taken;
    logic [mem_pkg::DATA_W-1:0] br_addr;
    logic halt_req;
    logic [isa_pkg::REG_ADDR_W-1:0] rd_addr_0;
    logic [isa_pkg::REG_ADDR_W-1:0] rd_addr_1;
    logic [isa_pkg::REG_ADDR_W-1:0] dst_addr;
    logic [mem_pkg::DATA_W-1:0] rd_data_0;
    logic [mem_pkg::DATA_W-1:0] rd_data_1;
    logic gpr_we;
    logic wb_load;
    logic [isa_pkg::ALU_OP_W-1:0] alu_op;
    logic [mem_pkg::DATA_W-1:0] alu_in_0;
    logic [mem_pkg::DATA_W-1:0] alu_in_1;
    logic [mem_pkg::DATA_W-1:0] alu_out;
    logic [isa_pkg::MEM_OP_W-1:0] mem_op;
    logic [mem_pkg::DATA_W-1:0] store_data;
    logic [mem_pkg::DATA_W-1:0] load_data;
    logic mem_fault;
    logic [mem_pkg::WORD_ADDR_W-1:0] spm_addr;
    logic spm_en;
    logic spm_we;
    logic [mem_pkg::DATA_W-1:0] spm_wr_data;
    logic [mem_pkg::DATA_W-1:0] spm_rd_data;

    if_stage u_if_stage (
        .clk(clk),
        .reset(reset),
        .cpu_en(cpu_en),
        .br_taken(br_taken),
        .br_addr(br_addr),
        .halt_req(halt_req),
        .pc(pc),
        .fetch_en(fetch_en),
        .halted(halted)
    );

    decoder u_decoder (
        .insn(insn),
        .pc(pc),
        .fetch_en(fetch_en),
        .rd_data_0(rd_data_0),
        .rd_data_1(rd_data_1),
        .rd_addr_0(rd_addr_0),
        .rd_addr_1(rd_addr_1),
        .dst_addr(dst_addr),
        .gpr_we(gpr_we),
        .wb_load(wb_load),
        .alu_op(alu_op),
        .alu_in_0(alu_in_0),
        .alu_in_1(alu_in_1),
        .mem_op(mem_op),
        .store_data(store_data),
        .br_taken(br_taken),
        .br_addr(br_addr),
        .halt_req(halt_req)
    );

    gpr u_gpr (
        .clk(clk),
        .reset(reset),
        .we(gpr_we),
        .wb_load(wb_load),
        .mem_fault(mem_fault),
        .wr_addr(dst_addr),
        .alu_out(alu_out),
        .load_data(load_data),
        .rd_addr_0(rd_addr_0),
        .rd_addr_1(rd_addr_1),
        .rd_data_0(rd_data_0),
        .rd_data_1(rd_data_1)
    );

    alu u_alu (
        .alu_op(alu_op),
        .alu_in_0(alu_in_0),
        .alu_in_1(alu_in_1),
        .alu_out(alu_out)
    );

    mem_ctrl u_mem_ctrl (
        .cpu_en(cpu_en),
        .mem_op(mem_op),
        .alu_out(alu_out),
        .store_data(store_data),
        .spm_rd_data(spm_rd_data),
        .test_spm_en(test_spm_en),
        .test_spm_we(test_spm_we),
        .test_spm_addr(test_spm_addr),
        .test_spm_wr_data(test_spm_wr_data),
        .load_data(load_data),
        .mem_fault(mem_fault),
        .spm_addr(spm_addr),
        .spm_en(spm_en),
        .spm_we(spm_we),
        .spm_wr_data(spm_wr_data),
        .test_spm_rd_data(test_spm_rd_data)
    );

    // instruction port takes the word address of pc
    spm #(
        .spm_depth(spm_depth)
    ) u_spm (
        .clk(clk),
        .insn_addr(pc[mem_pkg::BYTE_ADDR_W-1:OFFSET_W]),
        .data_addr(spm_addr),
        .data_en(spm_en),
        .data_we(spm_we),
        .data_wr_data(spm_wr_data),
        .insn(insn),
        .data_rd_data(spm_rd_data)
    );

endmodule

//--- rtl/decoder.sv
module decoder (
    input  logic [mem_pkg::DATA_W-1:0]     insn,
    input  logic [mem_pkg::DATA_W-1:0]     pc,
    input  logic                           fetch_en,
    input  logic [mem_pkg::DATA_W-1:0]     rd_data_0,
    input  logic [mem_pkg::DATA_W-1:0]     rd_data_1,
    output logic [isa_pkg::REG_ADDR_W-1:0] rd_addr_0,
    output logic [isa_pkg::REG_ADDR_W-1:0] rd_addr_1,
    output logic [isa_pkg::REG_ADDR_W-1:0] dst_addr,
    output logic                           gpr_we,
    output logic                           wb_load,
    output logic [isa_pkg::ALU_OP_W-1:0]   alu_op,
    output logic [mem_pkg::DATA_W-1:0]     alu_in_0,
    output logic [mem_pkg::DATA_W-1:0]     alu_in_1,
    output logic [isa_pkg::MEM_OP_W-1:0]   mem_op,
    output logic [mem_pkg::DATA_W-1:0]     store_data,
    output logic                           br_taken,
    output logic [mem_pkg::DATA_W-1:0]     br_addr,
    output logic                           halt_req
);

    localparam int IMM_EXT_W = mem_pkg::DATA_W - isa_pkg::IMM_W;
    localparam int INSN_SHIFT = $clog2(isa_pkg::INSN_BYTES);

    logic [isa_pkg::OPCODE_W-1:0] opcode;
    logic [isa_pkg::REG_ADDR_W-1:0] rd;
    logic [isa_pkg::IMM_W-1:0] imm;
    logic [mem_pkg::DATA_W-1:0] imm_sext;
    logic [mem_pkg::DATA_W-1:0] imm_zext;
    logic [mem_pkg::DATA_W-1:0] br_target;
    logic rd_is_source;

    assign opcode = insn[isa_pkg::OPCODE_LSB +: isa_pkg::OPCODE_W];
    assign rd = insn[isa_pkg::RD_LSB +: isa_pkg::REG_ADDR_W];
    assign imm = insn[isa_pkg::IMM_W-1:0];
    assign imm_sext = {{IMM_EXT_W{imm[isa_pkg::IMM_W-1]}}, imm};
    assign imm_zext = {{IMM_EXT_W{1'b0}}, imm};
    assign br_target = pc + isa_pkg::INSN_BYTES + (imm_sext << INSN_SHIFT);

    // stores and compares read rd through the second port instead of rb
    assign rd_is_source = (opcode == isa_pkg::STORE) || (opcode == isa_pkg::BEQ) ||
                          (opcode == isa_pkg::BNE);

    assign rd_addr_0 = insn[isa_pkg::RA_LSB +: isa_pkg::REG_ADDR_W];
    assign rd_addr_1 = rd_is_source ? rd : insn[isa_pkg::RB_LSB +: isa_pkg::REG_ADDR_W];
    assign dst_addr = rd;
    assign store_data = rd_data_1;
    assign alu_in_0 = rd_data_0;

    always_comb begin
        gpr_we = 1'b0;
        wb_load = 1'b0;
        alu_op = isa_pkg::alu_add;
        alu_in_1 = rd_data_1;
        mem_op = isa_pkg::mem_none;
        br_taken = 1'b0;
        br_addr = br_target;
        halt_req = 1'b0;
        case (opcode)
            isa_pkg::ADD, isa_pkg::SUB, isa_pkg::AND, isa_pkg::OR,
            isa_pkg::XOR, isa_pkg::SHL, isa_pkg::SHR: begin
                gpr_we = 1'b1;
                case (opcode)
                    isa_pkg::SUB: alu_op = isa_pkg::alu_sub;
                    isa_pkg::AND: alu_op = isa_pkg::alu_and;
                    isa_pkg::OR: alu_op = isa_pkg::alu_or;
                    isa_pkg::XOR: alu_op = isa_pkg::alu_xor;
                    isa_pkg::SHL: alu_op = isa_pkg::alu_shl;
                    isa_pkg::SHR: alu_op = isa_pkg::alu_shr;
                    default: alu_op = isa_pkg::alu_add;
                endcase
            end
            isa_pkg::ADDI: begin
                gpr_we = 1'b1;
                alu_in_1 = imm_sext;
            end
            isa_pkg::ORI: begin
                gpr_we = 1'b1;
                alu_op = isa_pkg::alu_or;
                alu_in_1 = imm_zext;
            end
            isa_pkg::LOAD: begin
                gpr_we = 1'b1;
                wb_load = 1'b1;
                alu_in_1 = imm_sext;
                mem_op = isa_pkg::mem_load;
            end
            isa_pkg::STORE: begin
                alu_in_1 = imm_sext;
                mem_op = isa_pkg::mem_store;
            end
            isa_pkg::BEQ: br_taken = (rd_data_0 == rd_data_1);
            isa_pkg::BNE: br_taken = (rd_data_0 != rd_data_1);
            isa_pkg::JMP: begin
                // low bits dropped so the target is always a whole instruction
                br_taken = 1'b1;
                br_addr = {rd_data_0[mem_pkg::DATA_W-1:INSN_SHIFT], {INSN_SHIFT{1'b0}}};
            end
            isa_pkg::HALT: halt_req = 1'b1;
            default: ;
        endcase

        // nothing may change state while the core is stopped or halted
        if (!fetch_en) begin
            gpr_we = 1'b0;
            wb_load = 1'b0;
            mem_op = isa_pkg::mem_none;
            br_taken = 1'b0;
            halt_req = 1'b0;
        end
    end

endmodule

//--- rtl/gpr.sv
module gpr (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           we,
    input  logic                           wb_load,
    input  logic                           mem_fault,
    input  logic [isa_pkg::REG_ADDR_W-1:0] wr_addr,
    input  logic [mem_pkg::DATA_W-1:0]     alu_out,
    input  logic [mem_pkg::DATA_W-1:0]     load_data,
    input  logic [isa_pkg::REG_ADDR_W-1:0] rd_addr_0,
    input  logic [isa_pkg::REG_ADDR_W-1:0] rd_addr_1,
    output logic [mem_pkg::DATA_W-1:0]     rd_data_0,
    output logic [mem_pkg::DATA_W-1:0]     rd_data_1
);

    localparam int NUM_REGS = 2 ** isa_pkg::REG_ADDR_W;

    logic [mem_pkg::DATA_W-1:0] regs [NUM_REGS];
    logic [mem_pkg::DATA_W-1:0] wr_data;
    logic wr_en;

    assign wr_data = wb_load ? load_data : alu_out;

    // a faulted load keeps the old register value; r0 is never written
    assign wr_en = we && !(wb_load && mem_fault) && (wr_addr != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rd_data_0 = regs[rd_addr_0];
    assign rd_data_1 = regs[rd_addr_1];

    assert property (@(posedge clk) disable iff (reset) wb_load |-> we)
        else $error("load write-back selected without a register write");

endmodule

//--- rtl/if_stage.sv
module if_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      cpu_en,
    input  logic                      br_taken,
    input  logic [mem_pkg::DATA_W-1:0] br_addr,
    input  logic                      halt_req,
    output logic [mem_pkg::DATA_W-1:0] pc,
    output logic                      fetch_en,
    output logic                      halted
);

    // a halted core stops fetching until the next reset
    assign fetch_en = cpu_en && !halted;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
            halted <= 1'b0;
        end else if (fetch_en) begin
            if (halt_req) begin
                halted <= 1'b1;
            end else if (br_taken) begin
                pc <= br_addr;
            end else begin
                pc <= pc + isa_pkg::INSN_BYTES;
            end
        end
    end

    // branch and jump targets from the decoder must keep fetch word-aligned
    assert property (@(posedge clk) disable iff (reset)
        pc % isa_pkg::INSN_BYTES == 0)
        else $error("pc not word-aligned: %h", pc);

endmodule

//--- rtl/isa_pkg.sv
package isa_pkg;

    // layout of the one-word instruction
    localparam int INSN_BYTES = 4;
    localparam int OPCODE_W = 6;
    localparam int REG_ADDR_W = 5;
    localparam int IMM_W = 16;
    localparam int OPCODE_LSB = 26;
    localparam int RD_LSB = 21;
    localparam int RA_LSB = 16;
    localparam int RB_LSB = 11;

    // opcodes
    localparam logic [OPCODE_W-1:0] ADD = 6'h00;
    localparam logic [OPCODE_W-1:0] SUB = 6'h01;
    localparam logic [OPCODE_W-1:0] AND = 6'h02;
    localparam logic [OPCODE_W-1:0] OR = 6'h03;
    localparam logic [OPCODE_W-1:0] XOR = 6'h04;
    localparam logic [OPCODE_W-1:0] SHL = 6'h05;
    localparam logic [OPCODE_W-1:0] SHR = 6'h06;
    localparam logic [OPCODE_W-1:0] ADDI = 6'h08;
    localparam logic [OPCODE_W-1:0] ORI = 6'h09;
    localparam logic [OPCODE_W-1:0] LOAD = 6'h10;
    localparam logic [OPCODE_W-1:0] STORE = 6'h11;
    localparam logic [OPCODE_W-1:0] BEQ = 6'h18;
    localparam logic [OPCODE_W-1:0] BNE = 6'h19;
    localparam logic [OPCODE_W-1:0] JMP = 6'h1a;
    localparam logic [OPCODE_W-1:0] HALT = 6'h3f;

    localparam int ALU_OP_W = 3;
    localparam logic [ALU_OP_W-1:0] alu_add = 3'd0;
    localparam logic [ALU_OP_W-1:0] alu_sub = 3'd1;
    localparam logic [ALU_OP_W-1:0] alu_and = 3'd2;
    localparam logic [ALU_OP_W-1:0] alu_or = 3'd3;
    localparam logic [ALU_OP_W-1:0] alu_xor = 3'd4;
    localparam logic [ALU_OP_W-1:0] alu_shl = 3'd5;
    localparam logic [ALU_OP_W-1:0] alu_shr = 3'd6;

    localparam int MEM_OP_W = 2;
    localparam logic [MEM_OP_W-1:0] mem_none = 2'd0;
    localparam logic [MEM_OP_W-1:0] mem_load = 2'd1;
    localparam logic [MEM_OP_W-1:0] mem_store = 2'd2;

endpackage

//--- rtl/mem_ctrl.sv
module mem_ctrl (
    input  logic                            cpu_en,
    input  logic [isa_pkg::MEM_OP_W-1:0]    mem_op,
    input  logic [mem_pkg::DATA_W-1:0]      alu_out,
    input  logic [mem_pkg::DATA_W-1:0]      store_data,
    input  logic [mem_pkg::DATA_W-1:0]      spm_rd_data,
    input  logic                            test_spm_en,
    input  logic                            test_spm_we,
    input  logic [mem_pkg::WORD_ADDR_W-1:0] test_spm_addr,
    input  logic [mem_pkg::DATA_W-1:0]      test_spm_wr_data,
    output logic [mem_pkg::DATA_W-1:0]      load_data,
    output logic                            mem_fault,
    output logic [mem_pkg::WORD_ADDR_W-1:0] spm_addr,
    output logic                            spm_en,
    output logic                            spm_we,
    output logic [mem_pkg::DATA_W-1:0]      spm_wr_data,
    output logic [mem_pkg::DATA_W-1:0]      test_spm_rd_data
);

    localparam int OFFSET_W = mem_pkg::BYTE_ADDR_W - mem_pkg::WORD_ADDR_W;

    logic core_access;
    logic misaligned;

    assign core_access = (mem_op != isa_pkg::mem_none);
    assign misaligned = |alu_out[OFFSET_W-1:0];

    // a misaligned access is flagged and never reaches the SPM
    assign mem_fault = core_access && misaligned;

    assign load_data = spm_rd_data;

    always_comb begin
        if (cpu_en) begin
            spm_addr = alu_out[mem_pkg::BYTE_ADDR_W-1:OFFSET_W];
            spm_en = core_access && !misaligned;
            spm_we = (mem_op == isa_pkg::mem_store);
            spm_wr_data = store_data;
        end else begin
            spm_addr = test_spm_addr;
            spm_en = test_spm_en;
            spm_we = test_spm_we;
            spm_wr_data = test_spm_wr_data;
        end
    end

    assign test_spm_rd_data = cpu_en ? '0 : spm_rd_data;

    // the decoder gates every access with fetch_en, so the test port owns the SPM here
    always_comb begin
        assert final (cpu_en || mem_op == isa_pkg::mem_none)
            else $error("core memory access while the core is disabled");
    end

endmodule

//--- rtl/mem_pkg.sv
package mem_pkg;

    localparam int DATA_W = 32;

    // byte addresses come from the core and word addresses go to the SPM
    localparam int BYTE_ADDR_W = 32;
    localparam int WORD_ADDR_W = 30;

    // the default SPM size is in words and must be a power of two
    localparam int SPM_DEPTH_DEFAULT = 1024;

endpackage

//--- rtl/spm.sv
module spm #(
    parameter int spm_depth = mem_pkg::SPM_DEPTH_DEFAULT
) (
    input  logic                            clk,
    input  logic [mem_pkg::WORD_ADDR_W-1:0] insn_addr,
    input  logic [mem_pkg::WORD_ADDR_W-1:0] data_addr,
    input  logic                            data_en,
    input  logic                            data_we,
    input  logic [mem_pkg::DATA_W-1:0]      data_wr_data,
    output logic [mem_pkg::DATA_W-1:0]      insn,
    output logic [mem_pkg::DATA_W-1:0]      data_rd_data
);

    localparam int IDX_W = $clog2(spm_depth);

    logic [mem_pkg::DATA_W-1:0] mem [spm_depth];

    // the data port is the only one that writes
    always_ff @(posedge clk) begin
        if (data_en && data_we) begin
            mem[data_addr[IDX_W-1:0]] <= data_wr_data;
        end
    end

    // both reads are combinational so fetch and load finish in the same cycle
    assign insn = mem[insn_addr[IDX_W-1:0]];
    assign data_rd_data = mem[data_addr[IDX_W-1:0]];

    // an address past the end would silently alias onto a lower word
    assert property (@(posedge clk) data_en |-> data_addr < spm_depth)
        else $error("SPM data address %h out of range", data_addr);

endmodule

//--- tests/cpu_tests.txt
# T name | P word_addr w0 w1 w2 w3 : four words loaded from word_addr on, all hex
# E word_addr w0 w1 w2 w3 : four words expected from word_addr on after the core halts
T alu_ops
P 00 20201234 2040fffb 00611000 04811000
P 04 08a11000 0cc11000 10e11000 21000004
P 08 15214000 19424000 25618001 20000007
P 0c 44600100 44800104 44a00108 44c0010c
P 10 44e00110 45200114 45400118 4560011c
P 14 44000120 fc000000 00000000 00000000
P 48 ffffffff 00000000 00000000 00000000
E 40 0000122f 00001239 00001230 ffffffff
E 44 ffffedcf 00012340 0fffffff 00009235
E 48 00000000 00000000 00000000 00000000
T load_store
P 00 40200100 20410010 44400104 20600108
P 04 44230004 4083fff8 44830000 fc000000
P 40 89abcdef 00000000 00000000 00000000
E 40 89abcdef 89abcdff 89abcdef 89abcdef
T branches
P 00 20200005 20400005 20600007 60410001
P 04 44600100 44200104 60610001 44600108
P 08 64610001 4460010c 64410001 44200110
P 0c 20800040 68040000 44600114 44600118
P 10 4460011c fc000000 00000000 00000000
P 40 00000000 00000000 00000000 00000000
P 44 00000000 00000000 00000000 00000000
E 40 00000000 00000005 00000007 00000000
E 44 00000005 00000000 00000000 00000007
T loop_halt
P 00 2020000a 00420800 2021ffff 6401fffd
P 04 44400100 fc000000 44200104 00000000
P 40 00000000 cafef00d 00000000 00000000
E 40 00000037 cafef00d 00000000 00000000
T misaligned
P 00 20200102 20400055 44410000 20600077
P 04 40610000 44600108 4440010c fc000000
P 40 11111111 22222222 00000000 00000000
E 40 11111111 22222222 00000077 00000055

//--- tests/tb_clock.sv
module tb_clock #(
    parameter int period = 100,
    parameter int reset_cycles = 2
) (
    input  logic reset_req,
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2) clk = ~clk;
        end
    end

    // reset comes up at time zero and again on every request, and always drops on a falling edge
    initial begin
        reset = 1'b1;
        forever begin
            repeat (reset_cycles) @(negedge clk);
            reset = 1'b0;
            @(posedge reset_req);
            reset = 1'b1;
        end
    end

endmodule

//--- tests/tb_cpu_top.sv
module tb_cpu_top;

    localparam int halt_timeout = 2000;
    localparam int reset_timeout = 10;

    logic clk;
    logic reset;
    logic reset_req;
    logic cpu_en;
    logic test_spm_en;
    logic test_spm_we;
    logic [mem_pkg::WORD_ADDR_W-1:0] test_spm_addr;
    logic [mem_pkg::DATA_W-1:0] test_spm_wr_data;
    logic [mem_pkg::DATA_W-1:0] test_spm_rd_data;
    logic halted;

    // words to load before a run and words expected after it
    logic [mem_pkg::WORD_ADDR_W-1:0] load_addr [$];
    logic [mem_pkg::DATA_W-1:0] load_word [$];
    logic [mem_pkg::WORD_ADDR_W-1:0] exp_addr [$];
    logic [mem_pkg::DATA_W-1:0] exp_word [$];

    tb_clock clock_gen (
        .reset_req(reset_req),
        .clk(clk),
        .reset(reset)
    );

    cpu_top dut (
        .clk(clk),
        .reset(reset),
        .cpu_en(cpu_en),
        .test_spm_en(test_spm_en),
        .test_spm_we(test_spm_we),
        .test_spm_addr(test_spm_addr),
        .test_spm_wr_data(test_spm_wr_data),
        .test_spm_rd_data(test_spm_rd_data),
        .halted(halted)
    );

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (reset !== 1'b0 && cycles >= reset_timeout) begin
                $display("reset still active after %0d cycles", reset_timeout);
                abort_run();
            end
        end while (reset !== 1'b0);
        @(negedge clk);
    endtask

    task automatic reset_dut();
        @(negedge clk);
        reset_req = 1'b1;
        @(negedge clk);
        reset_req = 1'b0;
        wait_reset_release();
    endtask

    task automatic write_word(input logic [mem_pkg::WORD_ADDR_W-1:0] addr,
                              input logic [mem_pkg::DATA_W-1:0] data);
        @(negedge clk);
        test_spm_en = 1'b1;
        test_spm_we = 1'b1;
        test_spm_addr = addr;
        test_spm_wr_data = data;
        @(negedge clk);
        test_spm_en = 1'b0;
        test_spm_we = 1'b0;
    endtask

    task automatic check_word(input logic [mem_pkg::WORD_ADDR_W-1:0] addr,
                              input logic [mem_pkg::DATA_W-1:0] expected);
        logic [mem_pkg::DATA_W-1:0] got;
        @(negedge clk);
        test_spm_en = 1'b1;
        test_spm_we = 1'b0;
        test_spm_addr = addr;
        @(posedge clk);
        got = test_spm_rd_data;
        assert (got === expected) else begin
            $display("Mismatch at %0t: test_spm_rd_data[%h] is %h, expected %h",
                     $time, addr, got, expected);
            abort_run();
        end
    endtask

    // the test port must read zero for as long as the core owns the SPM
    task automatic run_until_halt(input logic [8*32-1:0] name);
        int cycles;
        @(negedge clk);
        assert (halted === 1'b0) else begin
            $display("Mismatch at %0t: halted is %b before the run, expected %b",
                     $time, halted, 1'b0);
            abort_run();
        end
        test_spm_en = 1'b0;
        cpu_en = 1'b1;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            assert (test_spm_rd_data === '0) else begin
                $display("Mismatch at %0t: test_spm_rd_data is %h with cpu_en high, expected %h",
                         $time, test_spm_rd_data, 32'h0);
                abort_run();
            end
            if (halted !== 1'b1 && cycles >= halt_timeout) begin
                $display("test %0s: core did not halt within %0d cycles", name, halt_timeout);
                abort_run();
            end
        end while (halted !== 1'b1);
        cpu_en = 1'b0;
    endtask

    task automatic execute_test(input logic [8*32-1:0] name);
        reset_dut();
        foreach (load_addr[i]) begin
            write_word(load_addr[i], load_word[i]);
        end
        foreach (load_addr[i]) begin
            check_word(load_addr[i], load_word[i]);
        end
        run_until_halt(name);
        foreach (exp_addr[i]) begin
            check_word(exp_addr[i], exp_word[i]);
        end
        $display("test %0s checked %0d words", name, exp_addr.size());
    endtask

    initial begin
        int fd;
        int fields;
        int tests;
        logic [7:0] tag;
        logic [8*32-1:0] name;
        logic [8*128-1:0] rest;
        logic [mem_pkg::WORD_ADDR_W-1:0] addr;
        logic [mem_pkg::DATA_W-1:0] words [4];
        reset_req = 1'b0;
        cpu_en = 1'b0;
        test_spm_en = 1'b0;
        test_spm_we = 1'b0;
        test_spm_addr = '0;
        test_spm_wr_data = '0;
        tests = 0;
        name = '0;
        fd = $fopen("tests/cpu_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open tests/cpu_tests.txt");
            abort_run();
        end
        wait_reset_release();
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "#") begin
                fields = $fgets(rest, fd);
            end else if (tag == "T") begin
                // a new header closes the test collected so far
                if (tests > 0) begin
                    execute_test(name);
                end
                fields = $fscanf(fd, "%s", name);
                if (fields != 1) begin
                    $display("test header without a name in test file");
                    abort_run();
                end
                tests++;
                load_addr.delete();
                load_word.delete();
                exp_addr.delete();
                exp_word.delete();
            end else if (tag == "P" || tag == "E") begin
                fields = $fscanf(fd, "%h %h %h %h %h", addr, words[0], words[1], words[2],
                                 words[3]);
                if (fields != 5) begin
                    $display("line in test file has fewer than five hex fields");
                    abort_run();
                end
                for (int i = 0; i < 4; i++) begin
                    if (tag == "P") begin
                        load_addr.push_back(addr);
                        load_word.push_back(words[i]);
                    end else begin
                        exp_addr.push_back(addr);
                        exp_word.push_back(words[i]);
                    end
                    addr = addr + 1'b1;
                end
            end else begin
                $display("unknown line type %0s in test file", tag);
                abort_run();
            end
        end
        $fclose(fd);
        if (tests == 0) begin
            $display("no tests found in test file");
            abort_run();
        end
        execute_test(name);
        $display("TB PASSED");
        $finish;
    end

endmodule
